/* src/id_pkg.sv */
// ------------------------------------------------
// Types and constants shared by the decode stage
// Compile first and refer to items as id_pkg::name
// ------------------------------------------------
package id_pkg;

  localparam int unsigned XLEN = 32;

  // ------------------------------------------------
  // RV32I major opcodes
  // ------------------------------------------------
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  // Functional unit; FU_NONE marks an excepting entry
  typedef enum logic [1:0] {
    FU_NONE,
    FU_ALU,
    FU_CTRL_FLOW,
    FU_LSU
  } fu_t;

  typedef enum logic [4:0] {
    // ALU
    ADD,
    SUB,
    SLL,
    SLT,
    SLTU,
    XOR,
    SRL,
    SRA,
    OR,
    AND,
    LUI,
    AUIPC,
    // Control flow
    JAL,
    JALR,
    BEQ,
    BNE,
    BLT,
    BGE,
    BLTU,
    BGEU,
    // Memory
    LW,
    SW
  } op_t;

  typedef enum logic [1:0] {
    EX_NONE,
    EX_FETCH_FAULT,
    EX_ILLEGAL_INSTR
  } ex_cause_t;

  // Entry handed over by fetch
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [31:0]     instr;
    logic            fetch_fault;
  } fetch_entry_t;

  // Decoded entry held for the issue stage
  typedef struct packed {
    logic [XLEN-1:0] pc;
    fu_t             fu;
    op_t             op;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [XLEN-1:0] imm;
    logic            use_imm;
    logic            is_compressed;
    ex_cause_t       ex_cause;
    logic [31:0]     orig_instr;
    logic            is_ctrl_flow;
  } issue_entry_t;

endpackage

/* src/rvc_expander.sv */
// ------------------------------------------------
// Expands supported RVC instructions to RV32I form
// Uncompressed words pass through untouched
// ------------------------------------------------
`timescale 1ns/1ns

module rvc_expander (
  input  logic [31:0] instr_i,
  output logic [31:0] instr_o,
  output logic        is_compressed_o,
  output logic        illegal_o
);

  logic [15:0] c;
  logic [2:0]  funct3;
  logic [4:0]  rd_rs1;
  logic [4:0]  rs2;
  // Short register fields map onto x8..x15
  logic [4:0]  rs1_p;
  logic [4:0]  rd_rs2_p;
  logic [11:0] lw_sw_off;
  logic [11:1] j_off;
  logic [8:1]  b_off;

  assign c        = instr_i[15:0];
  assign funct3   = c[15:13];
  assign rd_rs1   = c[11:7];
  assign rs2      = c[6:2];
  assign rs1_p    = {2'b01, c[9:7]};
  assign rd_rs2_p = {2'b01, c[4:2]};

  // Word offset of C.LW / C.SW, zero extended
  assign lw_sw_off = {5'b00000, c[5], c[12:10], c[6], 2'b00};

  // C.J offset, bit 11 is the sign
  assign j_off = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3]};

  // C.BEQZ / C.BNEZ offset, bit 8 is the sign
  assign b_off = {c[12], c[6:5], c[2], c[11:10], c[4:3]};

  assign is_compressed_o = (c[1:0] != 2'b11);

  always_comb begin
    instr_o   = instr_i;
    illegal_o = 1'b0;
    if (is_compressed_o) begin
      // Anything not rebuilt below stays zero and is flagged
      instr_o = '0;
      case (c[1:0])
        // ------------------------------------------------
        // Quadrant 0
        // ------------------------------------------------
        2'b00: begin
          case (funct3)
            3'b010: begin
              instr_o = {lw_sw_off, rs1_p, 3'b010, rd_rs2_p, id_pkg::OPC_LOAD};
            end
            3'b110: begin
              instr_o = {lw_sw_off[11:5], rd_rs2_p, rs1_p, 3'b010,
                         lw_sw_off[4:0], id_pkg::OPC_STORE};
            end
            default: illegal_o = 1'b1;
          endcase
        end
        // ------------------------------------------------
        // Quadrant 1
        // ------------------------------------------------
        2'b01: begin
          case (funct3)
            // C.ADDI becomes addi rd, rd, imm
            3'b000: begin
              instr_o = {{7{c[12]}}, c[6:2], rd_rs1, 3'b000, rd_rs1, id_pkg::OPC_OPIMM};
            end
            // C.LI becomes addi rd, x0, imm
            3'b010: begin
              instr_o = {{7{c[12]}}, c[6:2], 5'd0, 3'b000, rd_rs1, id_pkg::OPC_OPIMM};
            end
            // C.J becomes jal x0, offset
            3'b101: begin
              instr_o = {c[12], j_off[10:1], j_off[11], {8{c[12]}}, 5'd0, id_pkg::OPC_JAL};
            end
            // C.BEQZ / C.BNEZ, funct3 bit 0 picks beq or bne
            3'b110, 3'b111: begin
              instr_o = {c[12], {2{c[12]}}, b_off[8:5], 5'd0, rs1_p, 2'b00, c[13],
                         b_off[4:1], c[12], id_pkg::OPC_BRANCH};
            end
            default: illegal_o = 1'b1;
          endcase
        end
        // ------------------------------------------------
        // Quadrant 2
        // ------------------------------------------------
        default: begin
          if (funct3 == 3'b100 && rs2 != 5'd0) begin
            if (c[12]) begin
              // C.ADD
              instr_o = {7'b0000000, rs2, rd_rs1, 3'b000, rd_rs1, id_pkg::OPC_OP};
            end else begin
              // C.MV
              instr_o = {7'b0000000, rs2, 5'd0, 3'b000, rd_rs1, id_pkg::OPC_OP};
            end
          end else begin
            // C.JR, C.JALR, C.EBREAK and the rest are not supported
            illegal_o = 1'b1;
          end
        end
      endcase
    end
  end

endmodule

/* src/instr_decoder.sv */
// ------------------------------------------------
// RV32I decoder building the full issue entry
// Purely combinational, fed by the RVC expander
// ------------------------------------------------
`timescale 1ns/1ns

module instr_decoder (
  input  logic [31:0]          instr_i,
  input  logic                 is_compressed_i,
  input  logic                 illegal_i,
  input  id_pkg::fetch_entry_t fetch_i,
  output id_pkg::issue_entry_t entry_o
);

  logic [6:0]              opcode;
  logic [2:0]              funct3;
  logic [6:0]              funct7;
  logic [id_pkg::XLEN-1:0] imm_i;
  logic [id_pkg::XLEN-1:0] imm_s;
  logic [id_pkg::XLEN-1:0] imm_b;
  logic [id_pkg::XLEN-1:0] imm_u;
  logic [id_pkg::XLEN-1:0] imm_j;
  logic                    dec_illegal;
  id_pkg::issue_entry_t    dec;
  id_pkg::ex_cause_t       ex_cause;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Sign-extended immediates per format
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'h000};
  assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  // ------------------------------------------------
  // Opcode decode
  // ------------------------------------------------
  // use_imm marks that the immediate replaces the second register operand
  always_comb begin
    dec         = '0;
    dec_illegal = 1'b0;
    case (opcode)
      id_pkg::OPC_LUI, id_pkg::OPC_AUIPC: begin
        dec.fu      = id_pkg::FU_ALU;
        dec.op      = (opcode == id_pkg::OPC_LUI) ? id_pkg::LUI : id_pkg::AUIPC;
        dec.rd      = instr_i[11:7];
        dec.imm     = imm_u;
        dec.use_imm = 1'b1;
      end
      id_pkg::OPC_JAL: begin
        dec.fu           = id_pkg::FU_CTRL_FLOW;
        dec.op           = id_pkg::JAL;
        dec.rd           = instr_i[11:7];
        dec.imm          = imm_j;
        dec.use_imm      = 1'b1;
        dec.is_ctrl_flow = 1'b1;
      end
      id_pkg::OPC_JALR: begin
        dec.fu           = id_pkg::FU_CTRL_FLOW;
        dec.op           = id_pkg::JALR;
        dec.rs1          = instr_i[19:15];
        dec.rd           = instr_i[11:7];
        dec.imm          = imm_i;
        dec.use_imm      = 1'b1;
        dec.is_ctrl_flow = 1'b1;
        dec_illegal      = (funct3 != 3'b000);
      end
      id_pkg::OPC_BRANCH: begin
        dec.fu           = id_pkg::FU_CTRL_FLOW;
        dec.rs1          = instr_i[19:15];
        dec.rs2          = instr_i[24:20];
        dec.imm          = imm_b;
        dec.is_ctrl_flow = 1'b1;
        case (funct3)
          3'b000:  dec.op = id_pkg::BEQ;
          3'b001:  dec.op = id_pkg::BNE;
          3'b100:  dec.op = id_pkg::BLT;
          3'b101:  dec.op = id_pkg::BGE;
          3'b110:  dec.op = id_pkg::BLTU;
          3'b111:  dec.op = id_pkg::BGEU;
          default: dec_illegal = 1'b1;
        endcase
      end
      // Only word accesses are supported
      id_pkg::OPC_LOAD: begin
        dec.fu      = id_pkg::FU_LSU;
        dec.op      = id_pkg::LW;
        dec.rs1     = instr_i[19:15];
        dec.rd      = instr_i[11:7];
        dec.imm     = imm_i;
        dec.use_imm = 1'b1;
        dec_illegal = (funct3 != 3'b010);
      end
      id_pkg::OPC_STORE: begin
        dec.fu      = id_pkg::FU_LSU;
        dec.op      = id_pkg::SW;
        dec.rs1     = instr_i[19:15];
        dec.rs2     = instr_i[24:20];
        dec.imm     = imm_s;
        dec_illegal = (funct3 != 3'b010);
      end
      id_pkg::OPC_OPIMM: begin
        dec.fu      = id_pkg::FU_ALU;
        dec.rs1     = instr_i[19:15];
        dec.rd      = instr_i[11:7];
        dec.imm     = imm_i;
        dec.use_imm = 1'b1;
        case (funct3)
          3'b000: dec.op = id_pkg::ADD;
          3'b001: begin
            dec.op      = id_pkg::SLL;
            dec_illegal = (funct7 != 7'b0000000);
          end
          3'b010: dec.op = id_pkg::SLT;
          3'b011: dec.op = id_pkg::SLTU;
          3'b100: dec.op = id_pkg::XOR;
          // Shift right, funct7 bit 5 selects arithmetic
          3'b101: begin
            dec.op      = funct7[5] ? id_pkg::SRA : id_pkg::SRL;
            dec_illegal = ({funct7[6], funct7[4:0]} != 6'b000000);
          end
          3'b110: dec.op = id_pkg::OR;
          3'b111: dec.op = id_pkg::AND;
        endcase
      end
      id_pkg::OPC_OP: begin
        dec.fu  = id_pkg::FU_ALU;
        dec.rs1 = instr_i[19:15];
        dec.rs2 = instr_i[24:20];
        dec.rd  = instr_i[11:7];
        case ({funct7, funct3})
          10'b0000000_000: dec.op = id_pkg::ADD;
          10'b0100000_000: dec.op = id_pkg::SUB;
          10'b0000000_001: dec.op = id_pkg::SLL;
          10'b0000000_010: dec.op = id_pkg::SLT;
          10'b0000000_011: dec.op = id_pkg::SLTU;
          10'b0000000_100: dec.op = id_pkg::XOR;
          10'b0000000_101: dec.op = id_pkg::SRL;
          10'b0100000_101: dec.op = id_pkg::SRA;
          10'b0000000_110: dec.op = id_pkg::OR;
          10'b0000000_111: dec.op = id_pkg::AND;
          default:         dec_illegal = 1'b1;
        endcase
      end
      default: dec_illegal = 1'b1;
    endcase
  end

  // Fetch fault wins over an illegal encoding
  always_comb begin
    if (fetch_i.fetch_fault) begin
      ex_cause = id_pkg::EX_FETCH_FAULT;
    end else if (illegal_i || dec_illegal) begin
      ex_cause = id_pkg::EX_ILLEGAL_INSTR;
    end else begin
      ex_cause = id_pkg::EX_NONE;
    end
  end

  // An excepting entry carries no operation, only its context
  always_comb begin
    entry_o = dec;
    if (ex_cause != id_pkg::EX_NONE) begin
      entry_o = '0;
    end
    entry_o.pc            = fetch_i.pc;
    entry_o.is_compressed = is_compressed_i;
    entry_o.ex_cause      = ex_cause;
    entry_o.orig_instr    = fetch_i.instr;
  end

endmodule

/* src/issue_reg_ctrl.sv */
// ------------------------------------------------
// ID/issue pipeline register and its handshakes
// Fetch valid/ready in, issue valid/ack out
// ------------------------------------------------
`timescale 1ns/1ns

module issue_reg_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  // Decoded entry of the word currently offered by fetch
  input  id_pkg::issue_entry_t entry_i,
  input  logic                 fetch_valid_i,
  output logic                 fetch_ready_o,
  // Issue side
  output id_pkg::issue_entry_t issue_entry_o,
  output logic                 issue_valid_o,
  input  logic                 issue_ack_i
);

  logic                 valid_q;
  logic                 valid_d;
  logic                 load;
  id_pkg::issue_entry_t entry_q;

  // ------------------------------------------------
  // Handshake
  // ------------------------------------------------
  // Space is free when empty or when the held entry leaves this cycle
  assign fetch_ready_o = !valid_q || issue_ack_i;
  assign load          = fetch_valid_i && fetch_ready_o;

  // Next valid state
  always_comb begin
    valid_d = valid_q;
    if (issue_ack_i) begin
      valid_d = 1'b0;
    end
    if (load) begin
      valid_d = 1'b1;
    end
    // A flush drops the held entry and any entry taken on this edge
    if (flush_i) begin
      valid_d = 1'b0;
    end
  end

  // ------------------------------------------------
  // Registers
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_d;
    end
  end

  // Payload only moves on a fetch transfer
  always_ff @(posedge clk_i) begin
    if (load) begin
      entry_q <= entry_i;
    end
  end

  assign issue_entry_o = entry_q;
  assign issue_valid_o = valid_q;

endmodule

/* src/id_stage_top.sv */
// ------------------------------------------------
// Decode stage top: expander, decoder, issue reg
// ------------------------------------------------
`timescale 1ns/1ns

module id_stage_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  id_pkg::fetch_entry_t fetch_entry_i,
  input  logic                 fetch_valid_i,
  output logic                 fetch_ready_o,
  output id_pkg::issue_entry_t issue_entry_o,
  output logic                 issue_valid_o,
  input  logic                 issue_ack_i
);

  logic [31:0]          expanded_instr;
  logic                 is_compressed;
  logic                 is_illegal_c;
  id_pkg::issue_entry_t decoded_entry;

  rvc_expander u_rvc_expander (
    .instr_i         (fetch_entry_i.instr),
    .instr_o         (expanded_instr),
    .is_compressed_o (is_compressed),
    .illegal_o       (is_illegal_c)
  );

  instr_decoder u_instr_decoder (
    .instr_i         (expanded_instr),
    .is_compressed_i (is_compressed),
    .illegal_i       (is_illegal_c),
    .fetch_i         (fetch_entry_i),
    .entry_o         (decoded_entry)
  );

  issue_reg_ctrl u_issue_reg_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .entry_i       (decoded_entry),
    .fetch_valid_i (fetch_valid_i),
    .fetch_ready_o (fetch_ready_o),
    .issue_entry_o (issue_entry_o),
    .issue_valid_o (issue_valid_o),
    .issue_ack_i   (issue_ack_i)
  );

endmodule

/* sim/tb_ref_model.svh */
// ------------------------------------------------
// Reference decode model and instruction encoders
// Included inside the testbench module
// ------------------------------------------------
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                      logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
  return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                      logic [4:0] rd, logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                      logic [2:0] f3, logic [6:0] opc);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
endfunction

function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                      logic [2:0] f3, logic [6:0] opc);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc};
endfunction

function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
  return {imm, rd, opc};
endfunction

function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd, logic [6:0] opc);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc};
endfunction

// Equivalent 32-bit word of a compressed one, bit 32 flags an illegal encoding
function automatic logic [32:0] ref_expand(logic [15:0] c);
  logic [4:0]  rp1;
  logic [4:0]  rp2;
  logic [11:0] mo;
  rp1 = {2'b01, c[9:7]};
  rp2 = {2'b01, c[4:2]};
  mo  = {5'b00000, c[5], c[12:10], c[6], 2'b00};
  case ({c[1:0], c[15:13]})
    5'b00010: return {1'b0, enc_i(mo, rp1, 3'b010, rp2, id_pkg::OPC_LOAD)};
    5'b00110: return {1'b0, enc_s(mo, rp2, rp1, 3'b010, id_pkg::OPC_STORE)};
    5'b01000: return {1'b0, enc_i({{6{c[12]}}, c[12], c[6:2]}, c[11:7], 3'b000, c[11:7],
                                  id_pkg::OPC_OPIMM)};
    5'b01010: return {1'b0, enc_i({{6{c[12]}}, c[12], c[6:2]}, 5'd0, 3'b000, c[11:7],
                                  id_pkg::OPC_OPIMM)};
    5'b01101: return {1'b0, enc_j({{9{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2],
                                   c[11], c[5:3], 1'b0}, 5'd0, id_pkg::OPC_JAL)};
    5'b01110, 5'b01111: begin
      return {1'b0, enc_b({{4{c[12]}}, c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0}, 5'd0,
                          rp1, {2'b00, c[13]}, id_pkg::OPC_BRANCH)};
    end
    5'b10100: begin
      if (c[6:2] != 5'd0) begin
        return {1'b0, enc_r(7'd0, c[6:2], c[12] ? c[11:7] : 5'd0, 3'b000, c[11:7],
                            id_pkg::OPC_OP)};
      end
    end
    default: ;
  endcase
  return {1'b1, 32'd0};
endfunction

function automatic id_pkg::op_t alu_op(logic [2:0] f3, logic alt);
  case (f3)
    3'b000:  return alt ? id_pkg::SUB : id_pkg::ADD;
    3'b001:  return id_pkg::SLL;
    3'b010:  return id_pkg::SLT;
    3'b011:  return id_pkg::SLTU;
    3'b100:  return id_pkg::XOR;
    3'b101:  return alt ? id_pkg::SRA : id_pkg::SRL;
    3'b110:  return id_pkg::OR;
    default: return id_pkg::AND;
  endcase
endfunction

function automatic id_pkg::issue_entry_t ref_decode(id_pkg::fetch_entry_t f);
  logic [32:0]          x;
  logic [31:0]          w;
  logic [2:0]           f3;
  logic [6:0]           f7;
  logic                 ill;
  logic [31:0]          imm_i;
  id_pkg::issue_entry_t e;
  x     = (f.instr[1:0] != 2'b11) ? ref_expand(f.instr[15:0]) : {1'b0, f.instr};
  w     = x[31:0];
  ill   = x[32];
  f3    = w[14:12];
  f7    = w[31:25];
  imm_i = {{20{w[31]}}, w[31:20]};
  e     = '0;
  case (w[6:0])
    id_pkg::OPC_LUI, id_pkg::OPC_AUIPC: begin
      e.fu      = id_pkg::FU_ALU;
      e.op      = (w[6:0] == id_pkg::OPC_LUI) ? id_pkg::LUI : id_pkg::AUIPC;
      e.rd      = w[11:7];
      e.imm     = {w[31:12], 12'h000};
      e.use_imm = 1'b1;
    end
    id_pkg::OPC_JAL, id_pkg::OPC_JALR: begin
      e.fu           = id_pkg::FU_CTRL_FLOW;
      e.rd           = w[11:7];
      e.use_imm      = 1'b1;
      e.is_ctrl_flow = 1'b1;
      if (w[6:0] == id_pkg::OPC_JAL) begin
        e.op  = id_pkg::JAL;
        e.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      end else begin
        e.op  = id_pkg::JALR;
        e.rs1 = w[19:15];
        e.imm = imm_i;
        ill   = ill || (f3 != 3'b000);
      end
    end
    id_pkg::OPC_BRANCH: begin
      e.fu           = id_pkg::FU_CTRL_FLOW;
      e.rs1          = w[19:15];
      e.rs2          = w[24:20];
      e.imm          = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      e.is_ctrl_flow = 1'b1;
      case (f3)
        3'b000:  e.op = id_pkg::BEQ;
        3'b001:  e.op = id_pkg::BNE;
        3'b100:  e.op = id_pkg::BLT;
        3'b101:  e.op = id_pkg::BGE;
        3'b110:  e.op = id_pkg::BLTU;
        3'b111:  e.op = id_pkg::BGEU;
        default: ill = 1'b1;
      endcase
    end
    id_pkg::OPC_LOAD: begin
      e.fu      = id_pkg::FU_LSU;
      e.op      = id_pkg::LW;
      e.rs1     = w[19:15];
      e.rd      = w[11:7];
      e.imm     = imm_i;
      e.use_imm = 1'b1;
      ill       = ill || (f3 != 3'b010);
    end
    id_pkg::OPC_STORE: begin
      e.fu  = id_pkg::FU_LSU;
      e.op  = id_pkg::SW;
      e.rs1 = w[19:15];
      e.rs2 = w[24:20];
      e.imm = {{20{w[31]}}, w[31:25], w[11:7]};
      ill   = ill || (f3 != 3'b010);
    end
    id_pkg::OPC_OPIMM: begin
      e.fu      = id_pkg::FU_ALU;
      e.op      = alu_op(f3, (f3 == 3'b101) && (f7 == 7'h20));
      e.rs1     = w[19:15];
      e.rd      = w[11:7];
      e.imm     = imm_i;
      e.use_imm = 1'b1;
      ill = ill || (f3 == 3'b001 && f7 != 7'h00) ||
            (f3 == 3'b101 && f7 != 7'h00 && f7 != 7'h20);
    end
    id_pkg::OPC_OP: begin
      e.fu  = id_pkg::FU_ALU;
      e.op  = alu_op(f3, f7 == 7'h20);
      e.rs1 = w[19:15];
      e.rs2 = w[24:20];
      e.rd  = w[11:7];
      ill = ill || !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)));
    end
    default: ill = 1'b1;
  endcase
  // Fault first, then illegal encoding
  if (f.fetch_fault || ill) begin
    e          = '0;
    e.ex_cause = f.fetch_fault ? id_pkg::EX_FETCH_FAULT : id_pkg::EX_ILLEGAL_INSTR;
  end
  e.pc            = f.pc;
  e.is_compressed = (f.instr[1:0] != 2'b11);
  e.orig_instr    = f.instr;
  return e;
endfunction

`endif

/* sim/tb_id_stage.sv */
// ------------------------------------------------
// Testbench for the decode stage top level
// Scoreboard compares issued entries with ref_decode
// ------------------------------------------------
`timescale 1ns/1ns

module tb_id_stage;

  localparam int PERIOD_NS   = 4;
  localparam int LEN_RESET   = 10;
  localparam int LEN_DECODE  = 60;
  localparam int LEN_RVC     = 60;
  localparam int LEN_EXC     = 60;
  localparam int LEN_BP      = 700;
  localparam int LEN_FLUSH   = 40;
  localparam int WATCHDOG_NS =
    (LEN_RESET + LEN_DECODE + LEN_RVC + LEN_EXC + LEN_BP + LEN_FLUSH) * 2 * PERIOD_NS;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 flush_i;
  id_pkg::fetch_entry_t fetch_entry_i;
  logic                 fetch_valid_i;
  logic                 fetch_ready_o;
  id_pkg::issue_entry_t issue_entry_o;
  logic                 issue_valid_o;
  logic                 issue_ack_i;

  integer               seed = 32'hec6;
  int                   errors;
  int                   err_start;
  int                   tests;
  int                   ack_mode;
  string                test_name;
  id_pkg::issue_entry_t exp_q[$];
  id_pkg::issue_entry_t held_entry;
  logic                 hold_pending;
  logic                 flush_seen;

  `include "tb_ref_model.svh"

  id_stage_top DUT (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .fetch_entry_i (fetch_entry_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_ready_o (fetch_ready_o),
    .issue_entry_o (issue_entry_o),
    .issue_valid_o (issue_valid_o),
    .issue_ack_i   (issue_ack_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(PERIOD_NS / 2) clk_i = ~clk_i;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired, the run did not finish in time");
    $display("RESULT: FAIL");
    $finish;
  end

  // Acknowledge is always high in mode 0, random in mode 1 and low in mode 2
  always @(posedge clk_i) begin
    case (ack_mode)
      0:       issue_ack_i <= 1'b1;
      1:       issue_ack_i <= ($random(seed) % 2) != 0;
      default: issue_ack_i <= 1'b0;
    endcase
  end

  // ------------------------------------------------
  // Checks
  // ------------------------------------------------
  task automatic report_error(string what);
    errors++;
    $display("error in %s: %s", test_name, what);
  endtask

  task automatic check_entry(string label, id_pkg::issue_entry_t exp,
                             id_pkg::issue_entry_t act);
    if (exp !== act) begin
      errors++;
      $display("mismatch %s/%s expected %h actual %h", test_name, label, exp, act);
    end
  endtask

  task automatic check_valid(string label, logic exp, logic act);
    if (exp !== act) begin
      errors++;
      $display("mismatch %s/%s expected %b actual %b", test_name, label, exp, act);
    end
  endtask

  // Scoreboard sampling the values held before each edge
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (flush_seen) begin
        check_valid("valid after flush", 1'b0, issue_valid_o);
      end
      if (issue_valid_o) begin
        check_valid("ready while held", issue_ack_i, fetch_ready_o);
        if (hold_pending) begin
          check_entry("held entry", held_entry, issue_entry_o);
        end
      end else begin
        check_valid("ready while empty", 1'b1, fetch_ready_o);
      end
      if (issue_valid_o && issue_ack_i) begin
        if (exp_q.size() == 0) begin
          report_error("entry issued with no entry expected");
        end else begin
          check_entry("issued entry", exp_q.pop_front(), issue_entry_o);
        end
      end
      if (flush_i) begin
        exp_q.delete();
      end else if (fetch_valid_i && fetch_ready_o) begin
        exp_q.push_back(ref_decode(fetch_entry_i));
      end
      hold_pending = issue_valid_o && !issue_ack_i && !flush_i;
      held_entry   = issue_entry_o;
      flush_seen   = flush_i;
    end
  end

  // ------------------------------------------------
  // Stimulus
  // ------------------------------------------------
  // Starts right after a rising edge and returns right after the transfer edge
  task automatic send_word(logic [31:0] w, logic fault);
    id_pkg::fetch_entry_t f;
    f.pc          = $random(seed);
    f.pc[1:0]     = 2'b00;
    f.instr       = w;
    f.fetch_fault = fault;
    fetch_entry_i <= f;
    fetch_valid_i <= 1'b1;
    @(posedge clk_i);
    while (!fetch_ready_o) @(posedge clk_i);
  endtask

  task automatic idle_cycle();
    fetch_valid_i <= 1'b0;
    @(posedge clk_i);
  endtask

  function automatic logic [31:0] gen_rv32(int kind, logic [31:0] a, logic [31:0] b);
    logic [2:0]  f3;
    logic [11:0] imm;
    f3  = a[14:12];
    imm = b[11:0];
    case (kind)
      0: return enc_u(b[19:0], a[11:7], id_pkg::OPC_LUI);
      1: return enc_u(b[19:0], a[11:7], id_pkg::OPC_AUIPC);
      2: return enc_j({b[19:0], 1'b0}, a[11:7], id_pkg::OPC_JAL);
      3: return enc_i(imm, a[19:15], 3'b000, a[11:7], id_pkg::OPC_JALR);
      4: begin
        if (f3[2:1] == 2'b01) f3[2] = 1'b1;
        return enc_b({imm, 1'b0}, a[24:20], a[19:15], f3, id_pkg::OPC_BRANCH);
      end
      5: return enc_i(imm, a[19:15], 3'b010, a[11:7], id_pkg::OPC_LOAD);
      6: return enc_s(imm, a[24:20], a[19:15], 3'b010, id_pkg::OPC_STORE);
      7: begin
        if (f3 == 3'b001) imm[11:5] = 7'h00;
        if (f3 == 3'b101) imm[11:5] = {1'b0, b[30], 5'b00000};
        return enc_i(imm, a[19:15], f3, a[11:7], id_pkg::OPC_OPIMM);
      end
      default: begin
        return enc_r((f3 == 3'b000 || f3 == 3'b101) && b[30] ? 7'h20 : 7'h00,
                     a[24:20], a[19:15], f3, a[11:7], id_pkg::OPC_OP);
      end
    endcase
  endfunction

  // C.LW, C.SW, C.ADDI, C.LI, C.J, C.BEQZ, C.BNEZ, C.ADD or C.MV
  function automatic logic [31:0] gen_rvc(int kind, logic [31:0] a);
    logic [4:0]  qf;
    logic [31:0] w;
    case (kind)
      0:       qf = 5'b00_010;
      1:       qf = 5'b00_110;
      2:       qf = 5'b01_000;
      3:       qf = 5'b01_010;
      4:       qf = 5'b01_101;
      5:       qf = 5'b01_110;
      6:       qf = 5'b01_111;
      default: qf = 5'b10_100;
    endcase
    w = {a[31:16], qf[2:0], a[12:2], qf[4:3]};
    if (kind == 7 && a[6:2] == 5'd0) w[2] = 1'b1;
    return w;
  endfunction

  function automatic logic [31:0] gen_bad(int kind, logic [31:0] a);
    case (kind)
      0: return {a[31:16], 3'b000, a[12:2], 2'b00};
      1: return {a[31:16], 3'b011, a[12:2], 2'b01};
      2: return {a[31:16], 3'b000, a[12:2], 2'b10};
      3: return {a[31:16], 3'b100, a[12:7], 5'd0, 2'b10};
      4: return {a[31:7], 7'b1111111};
      5: return enc_r(7'h01, a[24:20], a[19:15], a[14:12], a[11:7], id_pkg::OPC_OP);
      6: return enc_i(a[31:20], a[19:15], 3'b000, a[11:7], id_pkg::OPC_LOAD);
      default: return enc_b({a[31:20], 1'b0}, a[24:20], a[19:15], 3'b010,
                            id_pkg::OPC_BRANCH);
    endcase
  endfunction

  task automatic start_test(string name);
    test_name = name;
    err_start = errors;
    tests++;
  endtask

  // Lets every expected entry leave and reports the test
  task automatic end_test();
    int n;
    n = 0;
    fetch_valid_i <= 1'b0;
    ack_mode      <= 0;
    @(negedge clk_i);
    while ((exp_q.size() != 0 || issue_valid_o) && n < 100) begin
      @(negedge clk_i);
      n++;
    end
    if (exp_q.size() != 0) report_error("expected entries were never issued");
    @(posedge clk_i);
    $display("test %s done, %0d errors", test_name, errors - err_start);
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    rst_ni        = 1'b0;
    flush_i       = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_entry_i = '0;
    issue_ack_i   = 1'b0;
    ack_mode      = 2;
    errors        = 0;
    tests         = 0;
    hold_pending  = 1'b0;
    flush_seen    = 1'b0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);

    start_test("reset");
    check_valid("valid", 1'b0, issue_valid_o);
    check_valid("ready", 1'b1, fetch_ready_o);
    end_test();

    start_test("rv32i");
    for (int k = 0; k < 9; k++) begin
      for (int j = 0; j < 4; j++) begin
        a = $random(seed);
        b = $random(seed);
        send_word(gen_rv32(k, a, b), 1'b0);
      end
    end
    end_test();

    start_test("compressed");
    for (int k = 0; k < 8; k++) begin
      for (int j = 0; j < 4; j++) begin
        a = $random(seed);
        send_word(gen_rvc(k, a), 1'b0);
      end
    end
    end_test();

    start_test("exceptions");
    for (int k = 0; k < 8; k++) begin
      a = $random(seed);
      b = $random(seed);
      send_word(gen_bad(k, a), 1'b0);
      send_word(gen_bad(k, a), 1'b1);
      send_word(gen_rv32(k, a, b), 1'b1);
    end
    end_test();

    start_test("backpressure");
    ack_mode <= 1;
    for (int k = 0; k < 150; k++) begin
      r = $random(seed);
      a = $random(seed);
      b = $random(seed);
      if (r[0]) idle_cycle();
      case (r[9:8])
        2'b00, 2'b01: send_word(gen_rv32(r[7:4] % 9, a, b), r[15:12] == 4'h0);
        2'b10:        send_word(gen_rvc(r[6:4], a), r[15:12] == 4'h0);
        default:      send_word(gen_bad(r[6:4], a), r[15:12] == 4'h0);
      endcase
    end
    end_test();

    start_test("flush");
    ack_mode <= 2;
    repeat (2) @(posedge clk_i);
    send_word(gen_rv32(7, $random(seed), $random(seed)), 1'b0);
    idle_cycle();
    idle_cycle();
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    @(posedge clk_i);
    // Flush on the same edge as a fetch transfer
    fetch_entry_i <= '{pc: 32'h100, instr: gen_rv32(8, $random(seed), 0), fetch_fault: 1'b0};
    fetch_valid_i <= 1'b1;
    flush_i       <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    idle_cycle();
    ack_mode <= 0;
    send_word(gen_rvc(2, $random(seed)), 1'b0);
    end_test();

    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+sim
src/id_pkg.sv
src/rvc_expander.sv
src/instr_decoder.sv
src/issue_reg_ctrl.sv
src/id_stage_top.sv
sim/tb_id_stage.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then look for the failure line in the log
verilator --binary --timing -Wno-fatal --top-module tb_id_stage -f vlog.f \
    -o tb_id_stage > build.log 2>&1 &&
  ./obj_dir/tb_id_stage > sim.log 2>&1 &&
  ! grep -q "RESULT: FAIL" sim.log &&
  grep -q "RESULT: PASS" sim.log &&
  echo "simulation passed" ||
  { echo "simulation failed, see build.log and sim.log"; exit 1; }
